/* all.f */
hw/lsu_pkg.sv
hw/mpu_regions.sv
hw/mpu_check.sv
hw/trap_latch.sv
hw/lsu_ctrl.sv
hw/harvard_lsu.sv
tb/dmem_model.sv
tb/tb_harvard_lsu.sv

/* hw/harvard_lsu.sv */
// Top level joining region table, checker, LSU controller and trap latch
`timescale 1ns/1ns

module harvard_lsu
  import lsu_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // Requester side
  input  logic                     req_i,
  input  lsu_req_t                 req_data_i,
  input  priv_e                    priv_i,
  output logic                     busy_o,
  output logic                     done_o,
  output logic [XLEN-1:0]          rdata_o,
  output trap_t                    trap_o,
  output logic                     trap_valid_o,
  input  logic                     trap_ack_i,
  // Memory port
  output logic                     mem_req_o,
  output mem_req_t                 mem_data_o,
  input  logic                     mem_rvalid_i,
  input  logic [XLEN-1:0]          mem_rdata_i,
  input  logic                     mem_fault_i,
  // Region programming
  input  logic                     prog_en_i,
  input  logic [REGION_IDX_W-1:0]  prog_idx_i,
  input  region_t                  prog_region_i,
  input  logic                     lock_i,
  output logic                     locked_o
);

  region_t [NUM_REGIONS-1:0] regions;
  access_t                   access;
  logic                      allow;
  logic                      harvard;
  logic                      trap_set;
  trap_t                     trap_data;

  mpu_regions u_regions (
    .clk           (clk),
    .rst_n         (rst_n),
    .prog_en_i     (prog_en_i),
    .prog_idx_i    (prog_idx_i),
    .prog_region_i (prog_region_i),
    .lock_i        (lock_i),
    .locked_o      (locked_o),
    .regions_o     (regions)
  );

  mpu_check u_check (
    .regions_i (regions),
    .access_i  (access),
    .allow_o   (allow),
    .harvard_o (harvard)
  );

  lsu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .req_data_i     (req_data_i),
    .priv_i         (priv_i),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .rdata_o        (rdata_o),
    .access_o       (access),
    .allow_i        (allow),
    .harvard_i      (harvard),
    .trap_set_o     (trap_set),
    .trap_data_o    (trap_data),
    .trap_pending_i (trap_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_data_o     (mem_data_o),
    .mem_rvalid_i   (mem_rvalid_i),
    .mem_rdata_i    (mem_rdata_i),
    .mem_fault_i    (mem_fault_i)
  );

  trap_latch u_trap (
    .clk          (clk),
    .rst_n        (rst_n),
    .trap_set_i   (trap_set),
    .trap_i       (trap_data),
    .trap_ack_i   (trap_ack_i),
    .trap_valid_o (trap_valid_o),
    .trap_o       (trap_o)
  );

endmodule

/* hw/lsu_ctrl.sv */
// Load/store/CLRMEM FSM with byte enables, store lane placement and load extension
`timescale 1ns/1ns

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_i,
  input  lsu_req_t         req_data_i,
  input  priv_e            priv_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [XLEN-1:0]  rdata_o,
  output access_t          access_o,
  input  logic             allow_i,
  input  logic             harvard_i,
  output logic             trap_set_o,
  output trap_t            trap_data_o,
  input  logic             trap_pending_i,
  output logic             mem_req_o,
  output mem_req_t         mem_data_o,
  input  logic             mem_rvalid_i,
  input  logic [XLEN-1:0]  mem_rdata_i,
  input  logic             mem_fault_i
);

  typedef enum logic [1:0] {IDLE, WAIT, CLR_CHECK, CLR_WAIT} state_e;

  state_e          state_q;
  state_e          state_d;
  lsu_req_t        req_q;
  logic            accept;
  logic            issue;
  logic            finish;
  logic            misalign;
  logic            clr_last;
  mem_req_t        mem_d;
  logic [XLEN-1:0] ld_shift;
  logic [XLEN-1:0] ld_ext;

  function automatic logic [CAUSE_W-1:0] access_cause(lsu_op_e op);
    return (op == OP_LOAD) ? CAUSE_LOAD_ACCESS : CAUSE_STORE_ACCESS;
  endfunction

  function automatic logic [CAUSE_W-1:0] misalign_cause(lsu_op_e op);
    return (op == OP_LOAD) ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
  endfunction

  function automatic logic [3:0] byte_en(ls_size_e size, logic [1:0] off);
    case (size)
      LS_B:    return 4'b0001 << off;
      LS_H:    return 4'b0011 << {off[1], 1'b0};
      default: return 4'b1111;
    endcase
  endfunction

  // Pending trap also blocks new work until it is acknowledged
  assign busy_o   = (state_q != IDLE) || trap_pending_i;
  assign accept   = req_i && !busy_o;
  assign clr_last = (req_q.len == XLEN'(1));

  // CLRMEM base is always word aligned
  always_comb begin
    if (req_data_i.op == OP_CLRMEM) begin
      misalign = |req_data_i.addr[1:0];
    end else begin
      case (req_data_i.size)
        LS_H:    misalign = req_data_i.addr[0];
        LS_W:    misalign = |req_data_i.addr[1:0];
        default: misalign = 1'b0;
      endcase
    end
  end

  // Checker query. Only supervisor requests ever reach the CLRMEM walk
  always_comb begin
    if (state_q == CLR_CHECK) begin
      access_o.addr     = req_q.addr;
      access_o.is_write = 1'b1;
      access_o.priv     = PRIV_S;
    end else begin
      access_o.addr     = req_data_i.addr;
      access_o.is_write = (req_data_i.op != OP_LOAD);
      access_o.priv     = priv_i;
    end
  end

  // --------------------
  // Next state and traps
  // --------------------
  always_comb begin
    state_d     = state_q;
    issue       = 1'b0;
    finish      = 1'b0;
    trap_set_o  = 1'b0;
    trap_data_o = '0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          finish = 1'b1;
          if (req_data_i.op == OP_CLRMEM && priv_i == PRIV_U) begin
            trap_set_o        = 1'b1;
            trap_data_o.cause = CAUSE_ILLEGAL_INSTR;
          end else if (misalign) begin
            trap_set_o        = 1'b1;
            trap_data_o.cause = misalign_cause(req_data_i.op);
            trap_data_o.tval  = req_data_i.addr;
          end else if (req_data_i.op == OP_CLRMEM) begin
            // Zero length finishes quietly
            if (req_data_i.len != '0) begin
              finish  = 1'b0;
              state_d = CLR_CHECK;
            end
          end else if (harvard_i) begin
            trap_set_o        = 1'b1;
            trap_data_o.cause = CAUSE_HARVARD;
            trap_data_o.tval  = req_data_i.addr;
          end else if (!allow_i) begin
            trap_set_o        = 1'b1;
            trap_data_o.cause = access_cause(req_data_i.op);
            trap_data_o.tval  = req_data_i.addr;
          end else begin
            finish  = 1'b0;
            issue   = 1'b1;
            state_d = WAIT;
          end
        end
      end
      WAIT: begin
        if (mem_rvalid_i) begin
          finish  = 1'b1;
          state_d = IDLE;
          if (mem_fault_i) begin
            trap_set_o        = 1'b1;
            trap_data_o.cause = access_cause(req_q.op);
            trap_data_o.tval  = mem_data_o.addr;
          end
        end
      end
      CLR_CHECK: begin
        if (harvard_i || !allow_i) begin
          finish            = 1'b1;
          state_d           = IDLE;
          trap_set_o        = 1'b1;
          trap_data_o.cause = harvard_i ? CAUSE_HARVARD : CAUSE_STORE_ACCESS;
          trap_data_o.tval  = req_q.addr;
        end else begin
          issue   = 1'b1;
          state_d = CLR_WAIT;
        end
      end
      CLR_WAIT: begin
        if (mem_rvalid_i) begin
          if (mem_fault_i) begin
            finish            = 1'b1;
            state_d           = IDLE;
            trap_set_o        = 1'b1;
            trap_data_o.cause = CAUSE_STORE_ACCESS;
            trap_data_o.tval  = mem_data_o.addr;
          end else if (clr_last) begin
            finish  = 1'b1;
            state_d = IDLE;
          end else begin
            state_d = CLR_CHECK;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // --------------------
  // Memory request
  // --------------------
  always_comb begin
    if (state_q == CLR_CHECK) begin
      mem_d.we    = 1'b1;
      mem_d.be    = 4'b1111;
      mem_d.addr  = req_q.addr;
      mem_d.wdata = '0;
    end else begin
      mem_d.we    = (req_data_i.op == OP_STORE);
      mem_d.be    = byte_en(req_data_i.size, req_data_i.addr[1:0]);
      mem_d.addr  = {req_data_i.addr[XLEN-1:2], 2'b00};
      // Store data moves up into its byte lanes
      mem_d.wdata = req_data_i.wdata << {req_data_i.addr[1:0], 3'b000};
    end
  end

  // Load lane down to bit 0, then extend
  assign ld_shift = mem_rdata_i >> {req_q.addr[1:0], 3'b000};

  always_comb begin
    case (req_q.size)
      LS_B:    ld_ext = {{(XLEN-8){!req_q.is_unsigned && ld_shift[7]}}, ld_shift[7:0]};
      LS_H:    ld_ext = {{(XLEN-16){!req_q.is_unsigned && ld_shift[15]}}, ld_shift[15:0]};
      default: ld_ext = ld_shift;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      mem_req_o <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      state_q   <= state_d;
      mem_req_o <= issue;
      done_o    <= finish;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_data_i;
    end
    if (issue) begin
      mem_data_o <= mem_d;
    end
    // Walk to the next word once the previous write came back clean
    if (state_q == CLR_WAIT && mem_rvalid_i) begin
      req_q.addr <= req_q.addr + XLEN'(4);
      req_q.len  <= req_q.len - XLEN'(1);
    end
    if (state_q == WAIT && mem_rvalid_i) begin
      rdata_o <= ld_ext;
    end
  end

  a_no_req_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    req_i |-> !busy_o
  ) else $error("req_i while busy_o");

  a_mem_be_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_req_o |-> (mem_data_o.be != 4'b0000)
  ) else $error("memory request with empty byte enables");

endmodule

/* hw/lsu_pkg.sv */
// Shared widths, trap cause codes, region count, operation enums and the LSU structs
package lsu_pkg;

  // --------------------
  // Widths and counts
  // --------------------
  localparam int unsigned XLEN         = 32;
  localparam int unsigned NUM_REGIONS  = 8;
  localparam int unsigned REGION_IDX_W = $clog2(NUM_REGIONS);
  localparam int unsigned CAUSE_W      = 5;

  // --------------------
  // Trap causes
  // --------------------
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSTR    = 5'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGNED  = 5'd4;
  localparam logic [CAUSE_W-1:0] CAUSE_LOAD_ACCESS      = 5'd5;
  localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGNED = 5'd6;
  localparam logic [CAUSE_W-1:0] CAUSE_STORE_ACCESS     = 5'd7;
  // Data access landed in an instruction-space region
  localparam logic [CAUSE_W-1:0] CAUSE_HARVARD          = 5'd24;

  typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_CLRMEM} lsu_op_e;
  typedef enum logic [1:0] {LS_B, LS_H, LS_W} ls_size_e;
  typedef enum logic {PRIV_U, PRIV_S} priv_e;

  // --------------------
  // Structs
  // --------------------
  // For CLRMEM addr is the base and len the word count
  typedef struct packed {
    lsu_op_e          op;
    ls_size_e         size;
    logic             is_unsigned;
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  wdata;
    logic [XLEN-1:0]  len;
  } lsu_req_t;

  // Inclusive address window with its permissions
  typedef struct packed {
    logic             valid;
    logic [XLEN-1:0]  base;
    logic [XLEN-1:0]  limit;
    logic             allow_r;
    logic             allow_w;
    logic             user_ok;
    logic             is_ispace;
  } region_t;

  typedef struct packed {
    logic             we;
    logic [3:0]       be;
    logic [XLEN-1:0]  addr;
    logic [XLEN-1:0]  wdata;
  } mem_req_t;

  typedef struct packed {
    logic [CAUSE_W-1:0] cause;
    logic [XLEN-1:0]    tval;
  } trap_t;

  typedef struct packed {
    logic [XLEN-1:0]  addr;
    logic             is_write;
    priv_e            priv;
  } access_t;

endpackage

/* hw/mpu_check.sv */
// Region match and permission check for one physical data access
`timescale 1ns/1ns

module mpu_check
  import lsu_pkg::*;
(
  input  region_t [NUM_REGIONS-1:0] regions_i,
  input  access_t                   access_i,
  output logic                      allow_o,
  output logic                      harvard_o
);

  logic    found;
  region_t sel;
  logic    perm_ok;
  logic    priv_ok;

  // Lowest index wins when windows overlap
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (!found && regions_i[i].valid &&
          (access_i.addr >= regions_i[i].base) &&
          (access_i.addr <= regions_i[i].limit)) begin
        found = 1'b1;
        sel   = regions_i[i];
      end
    end
  end

  // Stores and CLRMEM both need write permission
  assign perm_ok = access_i.is_write ? sel.allow_w : sel.allow_r;
  assign priv_ok = (access_i.priv == PRIV_S) || sel.user_ok;

  // Instruction space is never reachable from the data side
  assign harvard_o = found && sel.is_ispace;

  // No match, or a failed permission, shows as neither flag set
  assign allow_o = found && !sel.is_ispace && perm_ok && priv_ok;

endmodule

/* hw/mpu_regions.sv */
// Protection region table with its programming port and the sticky lock
`timescale 1ns/1ns

module mpu_regions
  import lsu_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          prog_en_i,
  input  logic [REGION_IDX_W-1:0]       prog_idx_i,
  input  region_t                       prog_region_i,
  input  logic                          lock_i,
  output logic                          locked_o,
  output region_t [NUM_REGIONS-1:0]     regions_o
);

  // --------------------
  // Lock
  // --------------------
  // Set once, only reset clears it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked_o <= 1'b0;
    end else if (lock_i) begin
      locked_o <= 1'b1;
    end
  end

  // --------------------
  // Region table
  // --------------------
  // All entries come up invalid so nothing is accessible before boot setup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regions_o <= '0;
    end else if (prog_en_i && !locked_o) begin
      regions_o[prog_idx_i] <= prog_region_i;
    end
  end

  // Table is frozen from the cycle after the lock is seen
  a_locked_frozen : assert property (
    @(posedge clk) disable iff (!rst_n)
    locked_o |=> $stable(regions_o)
  ) else $error("region table changed while locked");

endmodule

/* hw/trap_latch.sv */
// Pending trap flag with cause and value, held until acknowledged
`timescale 1ns/1ns

module trap_latch
  import lsu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  trap_set_i,
  input  trap_t trap_i,
  input  logic  trap_ack_i,
  output logic  trap_valid_o,
  output trap_t trap_o
);

  // A new trap in the ack cycle stays pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_valid_o <= 1'b0;
    end else if (trap_set_i) begin
      trap_valid_o <= 1'b1;
    end else if (trap_ack_i) begin
      trap_valid_o <= 1'b0;
    end
  end

  // Most recent cause and value
  always_ff @(posedge clk) begin
    if (trap_set_i) begin
      trap_o <= trap_i;
    end
  end

  a_trap_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (trap_valid_o && !trap_set_i) |=> $stable(trap_o)
  ) else $error("trap_o changed while pending");

endmodule

/* tb/dmem_model.sv */
// Word memory model with random response latency and a faulting address window
`timescale 1ns/1ns

module dmem_model
  import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mem_req_i,
  input  mem_req_t        mem_data_i,
  output logic            mem_rvalid_o,
  output logic [XLEN-1:0] mem_rdata_o,
  output logic            mem_fault_o
);

  localparam int unsigned     DEPTH    = 256;
  localparam logic [XLEN-1:0] FAULT_LO = 32'h0000_0380;
  localparam logic [XLEN-1:0] FAULT_HI = 32'h0000_03bf;

  logic [XLEN-1:0] mem [DEPTH];
  integer          seed;
  int unsigned     lat;
  mem_req_t        req;

  // Fill word carries its own byte address
  initial begin
    seed = 32'h66ba_e3b7;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'hc0de_0000 | (i << 2);
    end
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    mem_fault_o  = 1'b0;
  end

  task automatic respond(input mem_req_t r);
    logic [7:0]      idx;
    logic [XLEN-1:0] w;
    idx          = r.addr[9:2];
    w            = mem[idx];
    mem_rvalid_o = 1'b1;
    mem_fault_o  = (r.addr >= FAULT_LO) && (r.addr <= FAULT_HI);
    mem_rdata_o  = w;
    // Faulting writes leave the array alone
    if (r.we && !mem_fault_o) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          w[8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
      mem[idx] = w;
    end
  endtask

  // One request at a time, answered 1 to 4 cycles later
  always begin
    @(posedge clk);
    #2;
    mem_rvalid_o = 1'b0;
    mem_fault_o  = 1'b0;
    if (rst_n && mem_req_i) begin
      req = mem_data_i;
      lat = 1 + ($unsigned($random(seed)) % 4);
      repeat (lat) @(posedge clk);
      #2;
      respond(req);
    end
  end

endmodule

/* tb/tb_harvard_lsu.sv */
// Testbench for the LSU top level with region setup, stimulus table, mirror memory and report
`timescale 1ns/1ns

module tb_harvard_lsu
  import lsu_pkg::*;
();

  localparam int unsigned SETUP_CYCLES = 40;
  localparam int unsigned MAX_TESTS    = 64;

  typedef struct packed {
    lsu_op_e            op;
    ls_size_e           size;
    logic               is_unsigned;
    logic [XLEN-1:0]    addr;
    logic [XLEN-1:0]    wdata;
    logic [XLEN-1:0]    len;
    priv_e              priv;
    logic               has_trap;
    logic [CAUSE_W-1:0] cause;
    logic [XLEN-1:0]    tval;
    logic [XLEN-1:0]    rdata;
  } test_t;

  logic                    clk;
  logic                    rst_n;
  logic                    req_i;
  lsu_req_t                req_data_i;
  priv_e                   priv_i;
  logic                    busy_o;
  logic                    done_o;
  logic [XLEN-1:0]         rdata_o;
  trap_t                   trap_o;
  logic                    trap_valid_o;
  logic                    trap_ack_i;
  logic                    mem_req_o;
  mem_req_t                mem_data_o;
  logic                    mem_rvalid_i;
  logic [XLEN-1:0]         mem_rdata_i;
  logic                    mem_fault_i;
  logic                    prog_en_i;
  logic [REGION_IDX_W-1:0] prog_idx_i;
  region_t                 prog_region_i;
  logic                    lock_i;
  logic                    locked_o;

  test_t           tests [MAX_TESTS];
  logic [XLEN-1:0] mirror [256];
  int              num_tests;
  int              err_count;
  int              pass_count;
  int              fail_count;
  int              cycles;
  int              cycle_limit;
  int              max_len;

  harvard_lsu harvard_lsu_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .req_data_i    (req_data_i),
    .priv_i        (priv_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .rdata_o       (rdata_o),
    .trap_o        (trap_o),
    .trap_valid_o  (trap_valid_o),
    .trap_ack_i    (trap_ack_i),
    .mem_req_o     (mem_req_o),
    .mem_data_o    (mem_data_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_fault_i   (mem_fault_i),
    .prog_en_i     (prog_en_i),
    .prog_idx_i    (prog_idx_i),
    .prog_region_i (prog_region_i),
    .lock_i        (lock_i),
    .locked_o      (locked_o)
  );

  dmem_model dmem_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req_i    (mem_req_o),
    .mem_data_i   (mem_data_o),
    .mem_rvalid_o (mem_rvalid_i),
    .mem_rdata_o  (mem_rdata_i),
    .mem_fault_o  (mem_fault_i)
  );

  task automatic add_test(input lsu_op_e op, input ls_size_e size, input logic uns,
                          input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                          input logic [XLEN-1:0] len, input priv_e priv, input logic has_trap,
                          input logic [CAUSE_W-1:0] cause, input logic [XLEN-1:0] tval,
                          input logic [XLEN-1:0] rdata);
    tests[num_tests] = {op, size, uns, addr, wdata, len, priv, has_trap, cause, tval, rdata};
    num_tests++;
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  // Columns are op, size, unsigned, addr, wdata, len, priv, trap, cause, tval and load data
  task automatic build_table();
    add_test(OP_STORE, LS_W, 0, 'h010, 'h8123_45f6, 0, PRIV_S, 0, 0, 0, 0);
    add_test(OP_LOAD, LS_W, 0, 'h010, 0, 0, PRIV_S, 0, 0, 0, 'h8123_45f6);
    add_test(OP_LOAD, LS_B, 0, 'h010, 0, 0, PRIV_S, 0, 0, 0, 'hffff_fff6);
    add_test(OP_LOAD, LS_B, 1, 'h011, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0045);
    add_test(OP_LOAD, LS_B, 0, 'h012, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0023);
    add_test(OP_LOAD, LS_B, 0, 'h013, 0, 0, PRIV_S, 0, 0, 0, 'hffff_ff81);
    add_test(OP_LOAD, LS_B, 1, 'h013, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0081);
    add_test(OP_LOAD, LS_H, 0, 'h012, 0, 0, PRIV_S, 0, 0, 0, 'hffff_8123);
    add_test(OP_LOAD, LS_H, 1, 'h010, 0, 0, PRIV_S, 0, 0, 0, 'h0000_45f6);
    add_test(OP_STORE, LS_B, 0, 'h021, 'h0000_00a7, 0, PRIV_S, 0, 0, 0, 0);
    add_test(OP_STORE, LS_H, 0, 'h026, 'h0000_beef, 0, PRIV_S, 0, 0, 0, 0);
    add_test(OP_LOAD, LS_W, 0, 'h020, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_a720);
    add_test(OP_LOAD, LS_W, 0, 'h024, 0, 0, PRIV_U, 0, 0, 0, 'hbeef_0024);
    // Misaligned accesses leave memory alone
    add_test(OP_LOAD, LS_H, 0, 'h011, 0, 0, PRIV_S, 1, CAUSE_LOAD_MISALIGNED, 'h011, 0);
    add_test(OP_LOAD, LS_W, 0, 'h012, 0, 0, PRIV_S, 1, CAUSE_LOAD_MISALIGNED, 'h012, 0);
    add_test(OP_STORE, LS_W, 0, 'h011, 'hdead_beef, 0, PRIV_S, 1, CAUSE_STORE_MISALIGNED, 'h011, 0);
    add_test(OP_STORE, LS_H, 0, 'h013, 'h1234, 0, PRIV_S, 1, CAUSE_STORE_MISALIGNED, 'h013, 0);
    add_test(OP_LOAD, LS_W, 0, 'h010, 0, 0, PRIV_S, 0, 0, 0, 'h8123_45f6);
    // Region permissions
    add_test(OP_STORE, LS_W, 0, 'h140, 'h5555_aaaa, 0, PRIV_S, 1, CAUSE_STORE_ACCESS, 'h140, 0);
    add_test(OP_LOAD, LS_W, 0, 'h140, 0, 0, PRIV_U, 1, CAUSE_LOAD_ACCESS, 'h140, 0);
    add_test(OP_LOAD, LS_W, 0, 'h140, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_0140);
    add_test(OP_STORE, LS_B, 0, 'h203, 'h77, 0, PRIV_S, 1, CAUSE_HARVARD, 'h203, 0);
    add_test(OP_LOAD, LS_W, 0, 'h200, 0, 0, PRIV_U, 1, CAUSE_HARVARD, 'h200, 0);
    add_test(OP_LOAD, LS_W, 0, 'h1000, 0, 0, PRIV_S, 1, CAUSE_LOAD_ACCESS, 'h1000, 0);
    // CLRMEM runs
    add_test(OP_CLRMEM, LS_W, 0, 'h040, 0, 3, PRIV_S, 0, 0, 0, 0);
    add_test(OP_LOAD, LS_W, 0, 'h03c, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_003c);
    add_test(OP_LOAD, LS_W, 0, 'h040, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0000);
    add_test(OP_LOAD, LS_W, 0, 'h048, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0000);
    add_test(OP_LOAD, LS_W, 0, 'h04c, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_004c);
    add_test(OP_CLRMEM, LS_W, 0, 'h010, 0, 0, PRIV_S, 0, 0, 0, 0);
    add_test(OP_CLRMEM, LS_W, 0, 'h020, 0, 2, PRIV_U, 1, CAUSE_ILLEGAL_INSTR, 0, 0);
    add_test(OP_CLRMEM, LS_W, 0, 'h042, 0, 1, PRIV_S, 1, CAUSE_STORE_MISALIGNED, 'h042, 0);
    add_test(OP_LOAD, LS_W, 0, 'h010, 0, 0, PRIV_S, 0, 0, 0, 'h8123_45f6);
    add_test(OP_LOAD, LS_W, 0, 'h020, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_a720);
    add_test(OP_CLRMEM, LS_W, 0, 'h0f8, 0, 4, PRIV_S, 1, CAUSE_STORE_ACCESS, 'h100, 0);
    add_test(OP_LOAD, LS_W, 0, 'h0fc, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0000);
    add_test(OP_LOAD, LS_W, 0, 'h100, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_0100);
    // Memory fault window inside region 3
    add_test(OP_LOAD, LS_W, 0, 'h384, 0, 0, PRIV_S, 1, CAUSE_LOAD_ACCESS, 'h384, 0);
    add_test(OP_LOAD, LS_B, 0, 'h387, 0, 0, PRIV_S, 1, CAUSE_LOAD_ACCESS, 'h384, 0);
    add_test(OP_STORE, LS_W, 0, 'h388, 'h1111_2222, 0, PRIV_S, 1, CAUSE_STORE_ACCESS, 'h388, 0);
    add_test(OP_CLRMEM, LS_W, 0, 'h37c, 0, 3, PRIV_S, 1, CAUSE_STORE_ACCESS, 'h380, 0);
    add_test(OP_LOAD, LS_W, 0, 'h37c, 0, 0, PRIV_S, 0, 0, 0, 'h0000_0000);
    add_test(OP_LOAD, LS_W, 0, 'h3c0, 0, 0, PRIV_S, 0, 0, 0, 'hc0de_03c0);
    add_test(OP_STORE, LS_B, 0, 'h1f0, 'h99, 0, PRIV_U, 1, CAUSE_STORE_ACCESS, 'h1f0, 0);
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  // Expected load result from a mirror word
  function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
                                                 input logic [1:0] off, input ls_size_e size,
                                                 input logic uns);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (size)
      LS_B:    return uns ? {24'h0, b} : {{24{b[7]}}, b};
      LS_H:    return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default: return word;
    endcase
  endfunction

  task automatic update_mirror(input test_t t);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] k;
    logic [XLEN-1:0] w;
    a = t.addr;
    w = mirror[a[9:2]];
    if (t.op == OP_STORE && !t.has_trap) begin
      case (t.size)
        LS_B:    w[8*a[1:0] +: 8] = t.wdata[7:0];
        LS_H:    w[8*a[1:0] +: 16] = t.wdata[15:0];
        default: w = t.wdata;
      endcase
      mirror[a[9:2]] = w;
    end else if (t.op == OP_CLRMEM) begin
      // Words below the failing address are zeroed
      k = 0;
      while (k < t.len && !(t.has_trap && a >= t.tval)) begin
        mirror[a[9:2]] = '0;
        a = a + 4;
        k = k + 1;
      end
    end
  endtask

  task automatic program_region(input logic [REGION_IDX_W-1:0] idx, input logic [XLEN-1:0] base,
                                input logic [XLEN-1:0] limit, input logic r, input logic w,
                                input logic u, input logic ispace);
    prog_idx_i    = idx;
    prog_region_i = {1'b1, base, limit, r, w, u, ispace};
    prog_en_i     = 1'b1;
    @(posedge clk);
    #2;
    prog_en_i = 1'b0;
  endtask

  task automatic run_test(input int n);
    test_t           t;
    int              errs_at_start;
    logic [XLEN-1:0] exp_rd;
    t             = tests[n];
    errs_at_start = err_count;
    while (busy_o) begin
      @(posedge clk);
      #2;
    end
    req_data_i = {t.op, t.size, t.is_unsigned, t.addr, t.wdata, t.len};
    priv_i     = t.priv;
    req_i      = 1'b1;
    @(posedge clk);
    #2;
    req_i = 1'b0;
    while (!done_o) begin
      @(posedge clk);
      #2;
    end
    check_value("trap_valid_o", trap_valid_o, t.has_trap);
    // A pending trap keeps the requester held off
    check_value("busy_o", busy_o, t.has_trap);
    if (t.has_trap) begin
      check_value("trap_o.cause", trap_o.cause, t.cause);
      check_value("trap_o.tval", trap_o.tval, t.tval);
    end else if (t.op == OP_LOAD) begin
      exp_rd = load_value(mirror[t.addr[9:2]], t.addr[1:0], t.size, t.is_unsigned);
      check_value("rdata_o", rdata_o, t.rdata);
      check_value("rdata_o against mirror", rdata_o, exp_rd);
    end
    // Acknowledge whatever is pending so the next test can start
    trap_ack_i = trap_valid_o;
    @(posedge clk);
    #2;
    trap_ack_i = 1'b0;
    assert (!done_o) else begin
      $display("done_o stayed high for more than one cycle");
      err_count++;
    end
    check_value("trap_valid_o after ack", trap_valid_o, 1'b0);
    update_mirror(t);
    if (err_count == errs_at_start) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %0d op %0d size %0d addr %h: %s", n, t.op, t.size, t.addr,
             (err_count == errs_at_start) ? "pass" : "fail");
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a request never completed", cycles);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_n         = 1'b0;
    req_i         = 1'b0;
    req_data_i    = '0;
    priv_i        = PRIV_S;
    trap_ack_i    = 1'b0;
    prog_en_i     = 1'b0;
    prog_idx_i    = '0;
    prog_region_i = '0;
    lock_i        = 1'b0;
    num_tests     = 0;
    err_count     = 0;
    pass_count    = 0;
    fail_count    = 0;
    max_len       = 0;
    for (int i = 0; i < 256; i++) begin
      mirror[i] = 32'hc0de_0000 | (i << 2);
    end
    build_table();
    for (int i = 0; i < num_tests; i++) begin
      if (tests[i].op == OP_CLRMEM && int'(tests[i].len) > max_len) begin
        max_len = int'(tests[i].len);
      end
    end
    cycle_limit = num_tests * (max_len + 1) * 6 + SETUP_CYCLES;

    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    assert (!done_o && !mem_req_o && !trap_valid_o && !busy_o && !locked_o) else begin
      $display("outputs not idle after reset");
      err_count++;
    end

    program_region(0, 'h000, 'h0ff, 1, 1, 1, 0);
    program_region(1, 'h100, 'h1ff, 1, 0, 0, 0);
    program_region(2, 'h200, 'h2ff, 1, 1, 1, 1);
    program_region(3, 'h300, 'h3ff, 1, 1, 1, 0);
    lock_i = 1'b1;
    @(posedge clk);
    #2;
    lock_i = 1'b0;
    check_value("locked_o", locked_o, 1'b1);
    // Would open region 1 for writes if the lock failed
    program_region(1, 'h100, 'h1ff, 1, 1, 1, 0);
    check_value("locked_o", locked_o, 1'b1);

    for (int n = 0; n < num_tests; n++) begin
      run_test(n);
    end
    check_value("locked_o", locked_o, 1'b1);

    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             num_tests, pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
